//--- logic/rv32i_types_pkg.sv
/*
 * RV32I instruction-level types shared by the fetch front end.
 * Only the 32-bit base encoding is described; RV32C is not supported.
 * The branch immediate helpers assume a branch-format word.
 */

package rv32i_types_pkg;

    // Machine word, used for both PCs and instruction words
    typedef logic [31:0] word_t;

    // Major opcodes of the base integer set
    typedef enum logic [6:0] {
        LUI     = 7'b0110111,
        AUIPC   = 7'b0010111,
        JAL     = 7'b1101111,
        JALR    = 7'b1100111,
        BRANCH  = 7'b1100011,
        LOAD    = 7'b0000011,
        STORE   = 7'b0100011,
        IMMED   = 7'b0010011,
        REGREG  = 7'b0110011,
        MISCMEM = 7'b0001111,
        SYSTEM  = 7'b1110011
    } opcode_t;

    // Branch-format field layout, msb first
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_05;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm04_01;
        logic       imm11;
        opcode_t    opcode;
    } sbtype_t;

    // Raw 13-bit branch offset, bit 0 always zero
    function automatic logic [12:0] sb_imm(sbtype_t insn);
        return {insn.imm12, insn.imm11, insn.imm10_05, insn.imm04_01, 1'b0};
    endfunction

    // Branch offset sign extended to a full word
    function automatic word_t sb_offset(sbtype_t insn);
        logic [12:0] imm;
        imm = sb_imm(insn);
        return {{19{imm[12]}}, imm};
    endfunction

endpackage

//--- logic/front_end_pkg.sv
/*
 * Structs passed between the fetch front end and the rest of the core.
 * Word-sized fields follow rv32i_types_pkg::word_t.
 * The instruction bus is a plain request/busy bus, one transfer at a time.
 */

package front_end_pkg;

    // Control from the hazard unit
    typedef struct packed {
        logic                   pc_en;
        logic                   iren;
        logic                   if_ex_stall;
        logic                   if_ex_flush;
        logic                   insert_priv_pc;
        rv32i_types_pkg::word_t priv_pc;
        logic                   rollback;
        logic                   npc_sel;
    } hazard_ctrl_t;

    // PC sources resolved in execute
    typedef struct packed {
        rv32i_types_pkg::word_t brj_addr;
        rv32i_types_pkg::word_t rollback_pc;
    } ex_redirect_t;

    // Fetch to execute pipeline register
    typedef struct packed {
        logic                   valid;
        rv32i_types_pkg::word_t instr;
        rv32i_types_pkg::word_t pc;
        rv32i_types_pkg::word_t pc4;
        logic                   mal_insn;
        logic                   fault_insn;
        rv32i_types_pkg::word_t fault_addr;
        logic                   prediction;
        rv32i_types_pkg::word_t predicted_address;
    } fetch_ex_t;

    // Instruction bus request, held until busy drops
    typedef struct packed {
        logic                   ren;
        rv32i_types_pkg::word_t addr;
    } ibus_req_t;

    // Instruction bus response, rdata little-endian
    typedef struct packed {
        logic                   busy;
        rv32i_types_pkg::word_t rdata;
        logic                   error;
    } ibus_rsp_t;

    // BTB lookup request
    typedef struct packed {
        rv32i_types_pkg::word_t current_pc;
        logic                   is_branch;
        logic                   is_jump;
        rv32i_types_pkg::word_t imm_sb;
    } predict_query_t;

    // BTB lookup answer
    typedef struct packed {
        logic                   predict_taken;
        rv32i_types_pkg::word_t target_addr;
    } predict_result_t;

    // Training from execute
    typedef struct packed {
        logic                   valid;
        rv32i_types_pkg::word_t pc;
        logic                   taken;
        rv32i_types_pkg::word_t target;
    } predict_update_t;

endpackage

//--- logic/fetch_unit.sv
/*
 * Instruction bus master for a single fetch path.
 * Expects pc to stay stable while a transfer is in flight.
 * A misaligned pc is reported at once and never reaches the bus.
 * The fetched word and its error flag are held while the stage stalls.
 */

`timescale 1ns/1ns

module fetch_unit (
    input  logic                     CLK,
    input  logic                     nRST,
    input  logic                     ireq,
    input  logic                     stall,
    input  rv32i_types_pkg::word_t   pc,
    input  front_end_pkg::ibus_rsp_t ibus_rsp,
    output front_end_pkg::ibus_req_t ibus_req,
    output logic                     insn_ready,
    output logic                     insn_fault,
    output logic                     mal_addr,
    output rv32i_types_pkg::word_t   insn_out
);

    typedef enum logic [1:0] {
        st_idle,
        st_wait,
        st_hold
    } fetch_state_t;

    fetch_state_t           state;
    fetch_state_t           next_state;
    rv32i_types_pkg::word_t req_addr;
    rv32i_types_pkg::word_t rdata_swap;
    rv32i_types_pkg::word_t held_insn;
    logic                   held_fault;
    logic                   start_req;
    logic                   xfer_done;

    // Only word fetches, so the low PC bits must be zero
    assign mal_addr = (pc[1:0] != 2'b00);

    // New request straight from idle and then held from the latched address
    assign start_req    = (state == st_idle) && ireq && !mal_addr;
    assign ibus_req.ren  = start_req || (state == st_wait);
    assign ibus_req.addr = (state == st_wait) ? req_addr : pc;

    // Busy low with ren high closes the transfer
    assign xfer_done = ibus_req.ren && !ibus_rsp.busy;

    // Bus is little-endian
    assign rdata_swap = {ibus_rsp.rdata[7:0], ibus_rsp.rdata[15:8],
                         ibus_rsp.rdata[23:16], ibus_rsp.rdata[31:24]};

    assign insn_ready = (state == st_hold) || xfer_done ||
                        ((state == st_idle) && mal_addr);
    assign insn_out   = (state == st_hold) ? held_insn : rdata_swap;
    assign insn_fault = (state == st_hold) ? held_fault : (xfer_done && ibus_rsp.error);

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (start_req && ibus_rsp.busy) begin
                    next_state = st_wait;
                end else if (start_req && stall) begin
                    // Zero-wait transfer but the stage cannot take it yet
                    next_state = st_hold;
                end
            end
            st_wait: begin
                if (!ibus_rsp.busy) begin
                    next_state = stall ? st_hold : st_idle;
                end
            end
            st_hold: begin
                if (!stall) begin
                    next_state = st_idle;
                end
            end
            default: begin
                next_state = st_idle;
            end
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    // Latched request address and the fetched word with its error flag
    always_ff @(posedge CLK) begin
        if (start_req) begin
            req_addr <= pc;
        end
        if (xfer_done) begin
            held_insn  <= rdata_swap;
            held_fault <= ibus_rsp.error;
        end
    end

endmodule

//--- logic/branch_predictor.sv
/*
 * Direct-mapped branch target buffer with 2-bit saturating counters.
 * BTB_ENTRIES must be a power of two; PC bits [1:0] are not used.
 * Lookup is combinational, training from execute lands at the clock edge.
 */

`timescale 1ns/1ns

module branch_predictor #(
    parameter int BTB_ENTRIES = 16
) (
    input  logic                           CLK,
    input  logic                           nRST,
    input  front_end_pkg::predict_query_t  query,
    input  front_end_pkg::predict_update_t update,
    output front_end_pkg::predict_result_t result
);

    localparam int IDX_BITS = $clog2(BTB_ENTRIES);
    localparam int TAG_BITS = 30 - IDX_BITS;

    typedef struct packed {
        logic [TAG_BITS-1:0]    tag;
        rv32i_types_pkg::word_t target;
        logic [1:0]             cnt;
    } btb_entry_t;

    btb_entry_t             btb_mem [BTB_ENTRIES];
    logic [BTB_ENTRIES-1:0] btb_valid;

    logic [IDX_BITS-1:0] q_idx;
    logic [TAG_BITS-1:0] q_tag;
    btb_entry_t          q_entry;
    logic                q_hit;
    logic [IDX_BITS-1:0] u_idx;
    logic [TAG_BITS-1:0] u_tag;
    btb_entry_t          u_entry;
    btb_entry_t          u_next;
    logic                u_hit;

    // Lookup path
    assign q_idx   = query.current_pc[IDX_BITS+1:2];
    assign q_tag   = query.current_pc[31:IDX_BITS+2];
    assign q_entry = btb_mem[q_idx];
    assign q_hit   = btb_valid[q_idx] && (q_entry.tag == q_tag);

    // Jumps always taken on a hit, branches need a counter of 2 or 3
    assign result.predict_taken = q_hit &&
                                  (query.is_jump || (query.is_branch && q_entry.cnt[1]));
    assign result.target_addr   = q_entry.target;

    // Training path
    assign u_idx   = update.pc[IDX_BITS+1:2];
    assign u_tag   = update.pc[31:IDX_BITS+2];
    assign u_entry = btb_mem[u_idx];
    assign u_hit   = btb_valid[u_idx] && (u_entry.tag == u_tag);

    always_comb begin
        u_next.tag    = u_tag;
        u_next.target = update.target;
        if (!u_hit) begin
            // Fresh entry starts weakly biased
            u_next.cnt = update.taken ? 2'd2 : 2'd1;
        end else if (update.taken) begin
            u_next.cnt = (u_entry.cnt == 2'd3) ? 2'd3 : u_entry.cnt + 2'd1;
        end else begin
            u_next.cnt = (u_entry.cnt == 2'd0) ? 2'd0 : u_entry.cnt - 2'd1;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            btb_valid <= '0;
        end else if (update.valid) begin
            btb_valid[u_idx] <= 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (update.valid) begin
            btb_mem[u_idx] <= u_next;
        end
    end

endmodule

//--- logic/fetch_stage.sv
/*
 * PC register, next-PC choice and the fetch to execute register.
 * Next-PC priority is priv redirect, rollback, resolved branch or jump,
 * predicted target, then PC + 4.
 * The hazard unit is expected to stall while i_mem_busy is high.
 */

`timescale 1ns/1ns

module fetch_stage #(
    parameter rv32i_types_pkg::word_t RESET_PC = 32'h8000_0000
) (
    input  logic                           CLK,
    input  logic                           nRST,
    input  front_end_pkg::hazard_ctrl_t    ctrl,
    input  front_end_pkg::ex_redirect_t    redir,
    input  logic                           insn_ready,
    input  logic                           insn_fault,
    input  logic                           mal_addr,
    input  rv32i_types_pkg::word_t         insn,
    input  front_end_pkg::predict_result_t result,
    output logic                           ireq,
    output rv32i_types_pkg::word_t         pc_out,
    output front_end_pkg::predict_query_t  query,
    output front_end_pkg::fetch_ex_t       fetch_ex,
    output logic                           i_mem_busy
);

    rv32i_types_pkg::word_t  pc;
    rv32i_types_pkg::word_t  pc4;
    rv32i_types_pkg::word_t  npc;
    rv32i_types_pkg::word_t  instr_sq;
    rv32i_types_pkg::sbtype_t instr_sb;
    logic                    fault_any;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            pc <= RESET_PC;
        end else if (ctrl.pc_en) begin
            pc <= npc;
        end
    end

    assign pc4    = pc + 32'd4;
    assign pc_out = pc;

    // Faulting fetches are squashed to zero, which never decodes as a branch
    assign fault_any = insn_fault || mal_addr;
    assign instr_sq  = fault_any ? '0 : insn;
    assign instr_sb  = rv32i_types_pkg::sbtype_t'(instr_sq);

    // Early decode for the BTB lookup
    assign query.current_pc = pc;
    assign query.is_branch  = (instr_sb.opcode == rv32i_types_pkg::BRANCH);
    assign query.is_jump    = (instr_sb.opcode == rv32i_types_pkg::JAL) ||
                              (instr_sb.opcode == rv32i_types_pkg::JALR);
    assign query.imm_sb     = rv32i_types_pkg::sb_offset(instr_sb);

    // Fixed redirect priority
    always_comb begin
        if (ctrl.insert_priv_pc) begin
            npc = ctrl.priv_pc;
        end else if (ctrl.rollback) begin
            npc = redir.rollback_pc;
        end else if (ctrl.npc_sel) begin
            npc = redir.brj_addr;
        end else if (result.predict_taken) begin
            npc = result.target_addr;
        end else begin
            npc = pc4;
        end
    end

    assign ireq = ctrl.iren;

    // Busy until a word or a fault is available
    assign i_mem_busy = !insn_ready && !insn_fault;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            fetch_ex <= '0;
        end else if (ctrl.if_ex_flush && !ctrl.if_ex_stall) begin
            fetch_ex <= '0;
        end else if (!ctrl.if_ex_stall) begin
            // Faults still travel as valid entries for the trap logic
            fetch_ex.valid             <= 1'b1;
            fetch_ex.instr             <= instr_sq;
            fetch_ex.pc                <= pc;
            fetch_ex.pc4               <= pc4;
            fetch_ex.mal_insn          <= mal_addr;
            fetch_ex.fault_insn        <= insn_fault;
            fetch_ex.fault_addr        <= pc;
            fetch_ex.prediction        <= result.predict_taken;
            fetch_ex.predicted_address <= result.target_addr;
        end
    end

endmodule

//--- logic/fetch_front_end.sv
/*
 * Instruction fetch front end of the RV32I pipeline.
 * Word-aligned fetch only, no compressed instructions.
 * Hazard control, execute redirects and BTB training come from outside.
 */

`timescale 1ns/1ns

module fetch_front_end #(
    parameter rv32i_types_pkg::word_t RESET_PC    = 32'h8000_0000,
    parameter int                     BTB_ENTRIES = 16
) (
    input  logic                           CLK,
    input  logic                           nRST,
    input  front_end_pkg::hazard_ctrl_t    ctrl,
    input  front_end_pkg::ex_redirect_t    redir,
    input  front_end_pkg::predict_update_t update,
    input  front_end_pkg::ibus_rsp_t       ibus_rsp,
    output front_end_pkg::ibus_req_t       ibus_req,
    output front_end_pkg::fetch_ex_t       fetch_ex,
    output logic                           i_mem_busy,
    output rv32i_types_pkg::word_t         pc_f
);

    logic                           ireq;
    logic                           insn_ready;
    logic                           insn_fault;
    logic                           mal_addr;
    rv32i_types_pkg::word_t         insn;
    front_end_pkg::predict_query_t  query;
    front_end_pkg::predict_result_t result;

    fetch_stage #(
        .RESET_PC(RESET_PC)
    ) stage_i (
        .CLK,
        .nRST,
        .ctrl,
        .redir,
        .insn_ready,
        .insn_fault,
        .mal_addr,
        .insn,
        .result,
        .ireq,
        .pc_out(pc_f),
        .query,
        .fetch_ex,
        .i_mem_busy
    );

    // Bus side holds its word on the same stall as the pipeline register
    fetch_unit fetch_i (
        .CLK,
        .nRST,
        .ireq,
        .stall(ctrl.if_ex_stall),
        .pc(pc_f),
        .ibus_rsp,
        .ibus_req,
        .insn_ready,
        .insn_fault,
        .mal_addr,
        .insn_out(insn)
    );

    branch_predictor #(
        .BTB_ENTRIES(BTB_ENTRIES)
    ) btb_i (
        .CLK,
        .nRST,
        .query,
        .update,
        .result
    );

endmodule

//--- verification/clock_gen.sv
/*
 * Testbench clock and reset source.
 * Free running clock, nRST released a little after the last reset edge.
 */

`timescale 1ns/1ns

module clock_gen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 2
) (
    output logic CLK,
    output logic nRST
);

    initial begin
        CLK = 1'b0;
        forever #(PERIOD / 2) CLK = ~CLK;
    end

    // Release away from the edge so no flop sees it change mid-update
    initial begin
        nRST = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        #2 nRST = 1'b1;
    end

endmodule

//--- verification/fetch_model.svh
/*
 * Reference model for the fetch front end, included inside the testbench.
 * Memory image is 256 words, aliased across the address space by bits [9:2].
 * BTB mirror keys on the full word address, so BTB_N must match the DUT.
 */

`ifndef FETCH_MODEL_SVH
`define FETCH_MODEL_SVH

localparam int IMG_WORDS = 256;

// Instruction view of memory, the bus carries these byte swapped
rv32i_types_pkg::word_t imem [IMG_WORDS];
logic                   bad_word [IMG_WORDS];

// BTB mirror
logic                   btb_v [BTB_N];
rv32i_types_pkg::word_t btb_pc [BTB_N];
rv32i_types_pkg::word_t btb_tgt [BTB_N];
logic [1:0]             btb_cnt [BTB_N];

function automatic rv32i_types_pkg::word_t bswap(rv32i_types_pkg::word_t w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
endfunction

// Little-endian word as the bus returns it
function automatic rv32i_types_pkg::word_t bus_word(rv32i_types_pkg::word_t a);
    return bswap(imem[a[9:2]]);
endfunction

task automatic fill_image();
    rv32i_types_pkg::word_t w;
    for (int i = 0; i < IMG_WORDS; i++) begin
        w = $urandom;
        // Plenty of branches and jumps so the BTB gets exercised
        case ($urandom % 8)
            0: w[6:0] = 7'b1100011;
            1: w[6:0] = 7'b1101111;
            2: w[6:0] = 7'b1100111;
            default: ;
        endcase
        imem[i]     = w;
        bad_word[i] = ($urandom % 16) == 0;
    end
    for (int i = 0; i < BTB_N; i++) begin
        btb_v[i] = 1'b0;
    end
endtask

function automatic int btb_index(rv32i_types_pkg::word_t pc);
    return int'((pc >> 2) & (BTB_N - 1));
endfunction

// Word seen by execute, zero for misaligned or bus error fetches
function automatic rv32i_types_pkg::word_t exp_instr(rv32i_types_pkg::word_t pc);
    if (pc[1:0] != 2'b00 || bad_word[pc[9:2]]) begin
        return '0;
    end
    return imem[pc[9:2]];
endfunction

task automatic lookup(input rv32i_types_pkg::word_t pc, input rv32i_types_pkg::word_t instr,
                      output logic taken, output rv32i_types_pkg::word_t tgt);
    int   idx;
    logic hit;
    logic is_br;
    logic is_j;
    idx   = btb_index(pc);
    hit   = btb_v[idx] && (btb_pc[idx][31:2] == pc[31:2]);
    is_br = instr[6:0] == 7'b1100011;
    is_j  = (instr[6:0] == 7'b1101111) || (instr[6:0] == 7'b1100111);
    taken = hit && (is_j || (is_br && btb_cnt[idx] >= 2'd2));
    tgt   = btb_tgt[idx];
endtask

task automatic train(input front_end_pkg::predict_update_t u);
    int   idx;
    logic hit;
    idx = btb_index(u.pc);
    hit = btb_v[idx] && (btb_pc[idx][31:2] == u.pc[31:2]);
    if (!hit) begin
        btb_cnt[idx] = u.taken ? 2'd2 : 2'd1;
    end else if (u.taken && btb_cnt[idx] != 2'd3) begin
        btb_cnt[idx] = btb_cnt[idx] + 2'd1;
    end else if (!u.taken && btb_cnt[idx] != 2'd0) begin
        btb_cnt[idx] = btb_cnt[idx] - 2'd1;
    end
    btb_v[idx]   = 1'b1;
    btb_pc[idx]  = u.pc;
    btb_tgt[idx] = u.target;
endtask

function automatic front_end_pkg::fetch_ex_t make_entry(rv32i_types_pkg::word_t pc,
        rv32i_types_pkg::word_t instr, logic taken, rv32i_types_pkg::word_t tgt);
    front_end_pkg::fetch_ex_t e;
    e.valid             = 1'b1;
    e.instr             = instr;
    e.pc                = pc;
    e.pc4               = pc + 32'd4;
    e.mal_insn          = pc[1:0] != 2'b00;
    e.fault_insn        = !e.mal_insn && bad_word[pc[9:2]];
    e.fault_addr        = pc;
    e.prediction        = taken;
    e.predicted_address = tgt;
    return e;
endfunction

`endif

//--- verification/fetch_tb.sv
/*
 * Random regression for the fetch front end against the included model.
 * The testbench plays hazard unit, execute stage and instruction memory.
 * Stall is derived from i_mem_busy 3 ns after the edge, other inputs at 2 ns.
 */

`timescale 1ns/1ns

module fetch_tb;

    localparam rv32i_types_pkg::word_t RESET_PC = 32'h8000_0000;
    localparam int BTB_N  = 16;
    localparam int CYCLES = 4000;

    logic                           CLK;
    logic                           nRST;
    front_end_pkg::hazard_ctrl_t    ctrl;
    front_end_pkg::ex_redirect_t    redir;
    front_end_pkg::predict_update_t update;
    front_end_pkg::ibus_rsp_t       ibus_rsp;
    front_end_pkg::ibus_req_t       ibus_req;
    front_end_pkg::fetch_ex_t       fetch_ex;
    logic                           i_mem_busy;
    rv32i_types_pkg::word_t         pc_f;

    clock_gen clk_i (.CLK, .nRST);

    fetch_front_end #(
        .RESET_PC(RESET_PC),
        .BTB_ENTRIES(BTB_N)
    ) dut_i (
        .CLK, .nRST, .ctrl, .redir, .update, .ibus_rsp,
        .ibus_req, .fetch_ex, .i_mem_busy, .pc_f
    );

    `include "fetch_model.svh"

    rv32i_types_pkg::word_t   exp_pc;
    front_end_pkg::fetch_ex_t exp_fe;
    front_end_pkg::ibus_req_t prev_req;
    logic                     prev_busy;
    logic                     xstall;
    logic                     xfer_active;
    logic                     word_held;
    logic                     done_now;
    int                       wait_cnt;
    int                       idle_cycles;
    int                       entries;

    task automatic stop_on_error(string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_word(string name, rv32i_types_pkg::word_t act,
                              rv32i_types_pkg::word_t exp);
        if (act !== exp) begin
            stop_on_error($sformatf("MISMATCH %s: got %h expected %h", name, act, exp));
        end
    endtask

    task automatic check_flag(string name, logic act, logic exp);
        if (act !== exp) begin
            stop_on_error($sformatf("MISMATCH %s: got %h expected %h", name, act, exp));
        end
    endtask

    // Address only matters while a request is expected
    task automatic check_req(front_end_pkg::ibus_req_t act, front_end_pkg::ibus_req_t exp);
        if (act.ren !== exp.ren || (exp.ren && act.addr !== exp.addr)) begin
            stop_on_error($sformatf("MISMATCH ibus_req: got %h expected %h", act, exp));
        end
    endtask

    // Predicted address is a don't care without a prediction
    task automatic check_entry(front_end_pkg::fetch_ex_t act, front_end_pkg::fetch_ex_t exp);
        front_end_pkg::fetch_ex_t act_m;
        act_m = act;
        if (!exp.prediction) begin
            act_m.predicted_address = exp.predicted_address;
        end
        if (act_m !== exp) begin
            stop_on_error($sformatf("MISMATCH fetch_ex: got %h expected %h", act, exp));
        end
    endtask

    // Mostly aligned targets inside the image window
    function automatic rv32i_types_pkg::word_t rand_target();
        rv32i_types_pkg::word_t t;
        t = RESET_PC | (($urandom % 256) << 2);
        if (($urandom % 8) == 0) begin
            t[1:0] = 2'b10;
        end
        return t;
    endfunction

    // Memory responder with 0 to 3 busy cycles per transfer
    task automatic respond();
        if (xfer_active && !ibus_rsp.busy) begin
            xfer_active = 1'b0;
        end
        if (!xfer_active && ibus_req.ren) begin
            xfer_active = 1'b1;
            wait_cnt    = $urandom % 4;
        end else if (xfer_active && wait_cnt > 0) begin
            wait_cnt--;
        end
        ibus_rsp.busy  = xfer_active && wait_cnt != 0;
        ibus_rsp.rdata = bus_word(ibus_req.addr);
        ibus_rsp.error = bad_word[ibus_req.addr[9:2]];
    endtask

    task automatic drive_random();
        xstall               = ($urandom % 5) == 0;
        ctrl.if_ex_flush     = ($urandom % 10) == 0;
        ctrl.insert_priv_pc  = ($urandom % 16) == 0;
        ctrl.priv_pc         = rand_target();
        ctrl.rollback        = ($urandom % 12) == 0;
        redir.rollback_pc    = rand_target();
        ctrl.npc_sel         = ($urandom % 8) == 0;
        redir.brj_addr       = rand_target();
        update.valid         = ($urandom % 4) == 0;
        update.pc            = rand_target() & ~32'h3;
        update.taken         = ($urandom % 2) == 1;
        update.target        = rand_target();
    endtask

    initial begin
        int                       t;
        logic                     taken;
        rv32i_types_pkg::word_t   tgt;
        rv32i_types_pkg::word_t   instr;
        front_end_pkg::ibus_req_t exp_req;

        void'($urandom(32'h35d3_53ab));
        // Pipe held and memory busy until the first cycle of the run
        ctrl             = '0;
        ctrl.if_ex_stall = 1'b1;
        redir            = '0;
        update           = '0;
        ibus_rsp         = '0;
        ibus_rsp.busy    = 1'b1;
        xstall           = 1'b0;
        xfer_active      = 1'b0;
        word_held        = 1'b0;
        done_now         = 1'b0;
        wait_cnt         = 0;
        idle_cycles      = 0;
        entries          = 0;
        fill_image();

        // No request may appear while iren is low in reset
        t = 0;
        while (nRST !== 1'b1) begin
            if (t > 10) begin
                stop_on_error("reset was never released by the clock generator");
            end
            @(negedge CLK);
            check_req(ibus_req, '0);
            check_entry(fetch_ex, '0);
            check_word("pc_f", pc_f, RESET_PC);
            t++;
        end

        // Fetching starts once reset is released
        ctrl.iren = 1'b1;
        exp_pc    = RESET_PC;
        exp_fe    = '0;
        prev_req  = '0;
        prev_busy = 1'b0;

        for (int cyc = 0; cyc < CYCLES; cyc++) begin
            @(posedge CLK);
            #2;
            respond();
            drive_random();
            #1;
            // Hazard unit holds the pipe while the fetch is busy
            ctrl.if_ex_stall = i_mem_busy || xstall;
            ctrl.pc_en       = !ctrl.if_ex_stall;

            @(negedge CLK);
            // A word is available when memory drops busy or while one is held
            done_now = xfer_active && !ibus_rsp.busy;
            check_entry(fetch_ex, exp_fe);
            check_word("pc_f", pc_f, exp_pc);
            check_flag("i_mem_busy", i_mem_busy,
                       exp_pc[1:0] == 2'b00 && !word_held && !done_now);
            exp_req.ren  = 1'b1;
            exp_req.addr = exp_pc;
            // No request for a misaligned PC or while a fetched word waits
            if (exp_pc[1:0] != 2'b00 || word_held) begin
                check_req(ibus_req, '0);
            end else if (prev_req.ren && prev_busy) begin
                check_req(ibus_req, prev_req);
            end else begin
                check_req(ibus_req, exp_req);
            end
            prev_req  = ibus_req;
            prev_busy = ibus_rsp.busy;

            if (!ctrl.if_ex_stall) begin
                instr = exp_instr(exp_pc);
                lookup(exp_pc, instr, taken, tgt);
                exp_fe = ctrl.if_ex_flush ? '0 : make_entry(exp_pc, instr, taken, tgt);
                // Redirect priority from highest to lowest
                if (ctrl.insert_priv_pc) begin
                    exp_pc = ctrl.priv_pc;
                end else if (ctrl.rollback) begin
                    exp_pc = redir.rollback_pc;
                end else if (ctrl.npc_sel) begin
                    exp_pc = redir.brj_addr;
                end else if (taken) begin
                    exp_pc = tgt;
                end else begin
                    exp_pc = exp_pc + 32'd4;
                end
                word_held = 1'b0;
                entries++;
                idle_cycles = 0;
            end else begin
                word_held = word_held || done_now;
                idle_cycles++;
                if (idle_cycles > 50) begin
                    stop_on_error("fetch made no progress for 50 cycles");
                end
            end
            // Training lands at the coming edge after this cycle's lookup
            if (update.valid) begin
                train(update);
            end
        end

        if (entries < CYCLES / 8) begin
            stop_on_error("too few fetches completed during the run");
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

//--- filelist.f
+incdir+verification
logic/rv32i_types_pkg.sv
logic/front_end_pkg.sv
logic/fetch_unit.sv
logic/branch_predictor.sv
logic/fetch_stage.sv
logic/fetch_front_end.sv
verification/clock_gen.sv
verification/fetch_tb.sv

//--- run.sh
#!/bin/bash
# Build and run the fetch front end regression with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f filelist.f --top-module fetch_tb -o fetch_sim \
    > build.log 2>&1 || { cat build.log; echo "Build error"; exit 1; }

./obj_dir/fetch_sim > sim.log 2>&1

grep -q "Regression failed" sim.log && { tail -n 5 sim.log; exit 1; } || \
    { grep -q "Regression passed" sim.log && echo "PASS" || { tail -n 5 sim.log; exit 1; }; }
